//--- yzh.f
yzh_cmd_pkg.sv
yzh_data_pkg.sv
yzh_control.sv
yzh_operand_buffer.sv
yzh_mac.sv
yzh_top.sv
yzh_checker.sv
yzh_tb.sv

//--- yzh_cases.txt
# LX|LW value1 value2 pair : load X or W bank (hex words, pair 1 also writes value2)
# CX|CW : clear bank   R expected : run   RB expected stray : run with stray starts   E name
R 0000000000000000
E empty_run
LX 00000003 00000000 0
LX FFFFFFFB 00000000 0
LX 00000007 00000000 0
LX FFFFFFFE 00000000 0
LX 7FFFFFFF 00000000 0
LW 00000004 00000000 0
LW 00000006 00000000 0
LW FFFFFFF8 00000000 0
LW FFFFFFFF 00000000 0
LW 80000000 00000000 0
R C00000007FFFFFB8
E single_loads
CX
CW
LX 00000003 FFFFFFFB 1
LX 00000007 FFFFFFFE 1
LX 00000010 0000AAAA 0
LW 00000004 0000DEAD 0
LW 00000006 FFFFFFF8 1
LW FFFFFFFF 00000100 0
R FFFFFFFFFFFFFFB8
E paired_loads
CW
R 0000000000000000
LW 00000002 00000000 0
LW 00000003 00000000 0
R FFFFFFFFFFFFFFF7
E clear_w
CX
CW
LX 00000001 00000002 1
LX 00000003 00000004 1
LX 00000005 00000006 1
LX 00000007 00000008 1
LX 00000009 0000000A 1
LX 0000000B 0000000C 1
LX 0000000D 0000000E 1
LX 0000000F 00000010 1
LX 00000064 00000000 0
LW 00000001 00000001 1
LW 00000001 00000001 1
LW 00000001 00000001 1
LW 00000001 00000001 1
LW 00000001 00000001 1
LW 00000001 00000001 1
LW 00000001 00000001 1
LW 00000001 00000000 0
LW 00000005 FFFFFFFD 1
R FFFFFFFFFFFFFF9B
E wrap
RB FFFFFFFFFFFFFF9B 00001000
R FFFFFFFFFFFFFF9B
E busy_start

//--- yzh_checker.sv
// Dot-product result checker
`timescale 1ns/1ps

module yzh_checker
    import yzh_data_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         busy_i,
    input  logic         done_i,
    input  acc_t         result_i,
    input  logic         arm_i,
    input  acc_t         expected_i,
    input  logic         test_end_i,
    input  logic [127:0] test_name_i,
    output int           runs_o,
    output int           errors_o,
    output int           tests_o,
    output int           failed_tests_o
);

    acc_t expected_q  = '0;
    logic pending     = 1'b0;   // A run was started and its done is still due
    logic after_reset = 1'b0;
    int   runs        = 0;
    int   errors      = 0;
    int   tests       = 0;
    int   failed      = 0;
    int   test_errors = 0;

    assign runs_o         = runs;
    assign errors_o       = errors;
    assign tests_o        = tests;
    assign failed_tests_o = failed;

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_reset_state();
        if (busy_i !== 1'b0 || done_i !== 1'b0 || result_i !== '0) begin
            $display("FAIL %0t: after reset busy=%0b done=%0b result=%0d, expected all zero",
                     $time, busy_i, done_i, result_i);
            note_error();
        end
    endtask

    task automatic check_done();
        if (busy_i) begin
            $display("done_o rose while busy_o was still high at %0t ns", $time);
            note_error();
        end
        if (!pending) begin
            $display("second done pulse with no run pending at %0t ns", $time);
            note_error();
        end else begin
            runs++;
            if (result_i !== expected_q) begin
                $display("FAIL %0t: result %0d, expected %0d", $time, result_i, expected_q);
                note_error();
            end
            pending = 1'b0;
        end
    endtask

    task automatic report_test();
        if (pending) begin
            $display("test %0s ended with a run still waiting for done", test_name_i);
            note_error();
        end
        tests++;
        if (test_errors == 0) begin
            $display("test %0s: ok", test_name_i);
        end else begin
            failed++;
            $display("test %0s: %0d errors", test_name_i, test_errors);
        end
        test_errors = 0;
    endtask

    // Outputs are stable half a cycle after the edge that moves them
    always @(negedge clk_i) begin
        if (rst_i) begin
            pending     = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_reset_state();
                after_reset = 1'b0;
            end
            if (done_i) begin
                check_done();   // Closes the previous run before a new one is armed
            end
            if (arm_i) begin
                expected_q = expected_i;
                pending    = 1'b1;
            end
            if (test_end_i) begin
                report_test();
            end
        end
    end

endmodule

//--- yzh_cmd_pkg.sv
// Accelerator command codes
package yzh_cmd_pkg;

    // Host command code, sampled with start_i
    typedef enum logic [2:0] {
        CMD_NOP   = 3'd0,
        CMD_LD_W  = 3'd1,    // Load one or two weight words
        CMD_CLR_W = 3'd2,    // Zero the weight bank
        CMD_LD_X  = 3'd3,    // Load one or two data words
        CMD_CLR_X = 3'd4,    // Zero the data bank
        CMD_RUN   = 3'd5     // Walk both banks and accumulate
    } cmd_t;

    // Run sequencer states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,      // Accepting commands
        ST_RUN  = 2'd1,      // One entry pair per cycle
        ST_DONE = 2'd2       // Last product has landed
    } ctrl_state_t;

endpackage

//--- yzh_control.sv
// Command decode and run sequencer
`timescale 1ns/1ps

module yzh_control
    import yzh_cmd_pkg::*;
    import yzh_data_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic clk_i,
    input  logic rst_i,
    input  cmd_t cmd_i,
    input  logic start_i,
    input  logic pair_i,
    output logic x_wr1_en_o,
    output logic x_wr2_en_o,
    output logic x_clr_o,
    output logic w_wr1_en_o,
    output logic w_wr2_en_o,
    output logic w_clr_o,
    output logic rd_rewind_o,
    output logic rd_en_o,
    output logic acc_clr_o,
    output logic acc_en_o,
    output logic busy_o,
    output logic done_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       run_cnt_q;
    logic        done_q;
    logic        accept;
    logic        run_last;

    assign accept   = start_i && (state_q == ST_IDLE);   // Starts while busy are dropped
    assign run_last = (run_cnt_q == addr_t'(DEPTH - 1));

    // Command strobes are combinational so loads land on the start edge
    always_comb begin
        x_wr1_en_o  = 1'b0;
        x_wr2_en_o  = 1'b0;
        x_clr_o     = 1'b0;
        w_wr1_en_o  = 1'b0;
        w_wr2_en_o  = 1'b0;
        w_clr_o     = 1'b0;
        rd_rewind_o = 1'b0;
        acc_clr_o   = 1'b0;
        if (accept) begin
            case (cmd_i)
                CMD_LD_X: begin
                    x_wr1_en_o = 1'b1;
                    x_wr2_en_o = pair_i;
                end
                CMD_CLR_X: x_clr_o = 1'b1;
                CMD_LD_W: begin
                    w_wr1_en_o = 1'b1;
                    w_wr2_en_o = pair_i;
                end
                CMD_CLR_W: w_clr_o = 1'b1;
                CMD_RUN: begin
                    rd_rewind_o = 1'b1;
                    acc_clr_o   = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (accept && cmd_i == CMD_RUN) state_d = ST_RUN;
            ST_RUN:  if (run_last) state_d = ST_DONE;
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            run_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            run_cnt_q <= (state_q == ST_RUN) ? run_cnt_q + addr_t'(1) : '0;
            done_q    <= (state_q == ST_DONE);   // Pulse on the edge leaving DONE
        end
    end

    assign rd_en_o  = (state_q == ST_RUN);
    assign acc_en_o = (state_q == ST_RUN);
    assign busy_o   = (state_q != ST_IDLE);
    assign done_o   = done_q;

    // X bank, W bank and run sequencing never overlap
    assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({x_wr1_en_o | x_clr_o,
                  w_wr1_en_o | w_clr_o,
                  rd_rewind_o | rd_en_o}));

    // Run spans DEPTH accumulate cycles before the done pulse
    assert property (@(posedge clk_i) disable iff (rst_i)
        acc_clr_o |-> ##(DEPTH + 2) done_o);

endmodule

//--- yzh_data_pkg.sv
// Datapath vector types
package yzh_data_pkg;

    // Signed operand held in either bank
    typedef logic signed [31:0] word_t;

    // Entry index into a 16-deep bank
    typedef logic [3:0] addr_t;

    // Running dot-product sum
    typedef logic signed [63:0] acc_t;

endpackage

//--- yzh_mac.sv
// Signed multiply-accumulate
`timescale 1ns/1ps

module yzh_mac
    import yzh_data_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  clr_i,
    input  logic  en_i,
    input  word_t x_i,
    input  word_t w_i,
    output acc_t  acc_o
);

    acc_t product;
    acc_t acc_q;

    // Both operands sign-extended so the full 64-bit product is kept
    assign product = acc_t'(x_i) * acc_t'(w_i);

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            acc_q <= '0;
        end else if (en_i) begin
            acc_q <= acc_q + product;   // Wraps silently on overflow
        end
    end

    assign acc_o = acc_q;

    assert property (@(posedge clk_i) disable iff (rst_i)
        !(clr_i && en_i));

endmodule

//--- yzh_operand_buffer.sv
// Operand bank with sequential read
`timescale 1ns/1ps

module yzh_operand_buffer
    import yzh_data_pkg::*;
#(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  clr_i,
    input  logic  wr1_en_i,
    input  logic  wr2_en_i,
    input  word_t wr1_data_i,
    input  word_t wr2_data_i,
    input  logic  rd_rewind_i,
    input  logic  rd_en_i,
    output word_t rd_data_o
);

    logic [WIDTH-1:0] mem [DEPTH];
    addr_t            wr_ptr_q;
    addr_t            rd_ptr_q;
    addr_t            wr_ptr_inc;

    // Next entry index, wrapping at the bank depth
    function automatic addr_t next_idx(input addr_t idx);
        addr_t nxt;
        if (idx == addr_t'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + addr_t'(1);
        end
        return nxt;
    endfunction

    assign wr_ptr_inc = next_idx(wr_ptr_q);

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            wr_ptr_q <= '0;
        end else if (wr1_en_i) begin
            mem[wr_ptr_q] <= wr1_data_i;
            if (wr2_en_i) begin
                mem[wr_ptr_inc] <= wr2_data_i;    // Second word may land on entry 0
                wr_ptr_q        <= next_idx(wr_ptr_inc);
            end else begin
                wr_ptr_q <= wr_ptr_inc;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clr_i || rd_rewind_i) begin
            rd_ptr_q <= '0;
        end else if (rd_en_i) begin
            rd_ptr_q <= next_idx(rd_ptr_q);
        end
    end

    assign rd_data_o = mem[rd_ptr_q];   // Presented to the MAC in the same cycle

    assert property (@(posedge clk_i) disable iff (rst_i)
        wr2_en_i |-> wr1_en_i);

endmodule

//--- yzh_tb.sv
// Dot-product accelerator testbench
`timescale 1ns/1ps

module yzh_tb
    import yzh_cmd_pkg::*;
    import yzh_data_pkg::*;
();

    localparam int DEPTH        = 16;
    localparam int WIDTH        = 32;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_TIMEOUT = 4 * DEPTH;
    localparam int DONE_TIMEOUT = 4 * DEPTH;
    localparam int QUIET_CYCLES = 2 * DEPTH;   // Room for a stray second done

    logic         clk = 1'b0;
    logic         rst;
    cmd_t         cmd;
    logic         start;
    logic         pair;
    word_t        value1;
    word_t        value2;
    logic         busy;
    logic         done;
    acc_t         result;
    logic         arm;
    acc_t         expected_sum;
    logic         test_end;
    logic [127:0] test_name;
    int           runs;
    int           errors;
    int           tests;
    int           failed_tests;
    int           tb_errors;
    int           fd;

    always #(CLK_PERIOD / 2) clk = ~clk;

    yzh_top #(
        .DEPTH(DEPTH),
        .WIDTH(WIDTH)
    ) u_yzh_top (
        .clk_i   (clk),
        .rst_i   (rst),
        .cmd_i   (cmd),
        .start_i (start),
        .pair_i  (pair),
        .value1_i(value1),
        .value2_i(value2),
        .busy_o  (busy),
        .done_o  (done),
        .result_o(result)
    );

    yzh_checker u_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .busy_i        (busy),
        .done_i        (done),
        .result_i      (result),
        .arm_i         (arm),
        .expected_i    (expected_sum),
        .test_end_i    (test_end),
        .test_name_i   (test_name),
        .runs_o        (runs),
        .errors_o      (errors),
        .tests_o       (tests),
        .failed_tests_o(failed_tests)
    );

    task automatic abort_run(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("sim failed");
        $finish;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (busy) begin
            abort_run("timeout: busy_o never went low");
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (!done) begin
            abort_run("timeout: no done pulse after a run");
        end
    endtask

    // One-cycle start strobe, sampled at the next rising edge
    task automatic drive_start(input cmd_t c, input word_t v1, input word_t v2,
                               input logic p);
        cmd    = c;
        value1 = v1;
        value2 = v2;
        pair   = p;
        start  = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        cmd   = CMD_NOP;
        pair  = 1'b0;
    endtask

    task automatic send_cmd(input cmd_t c, input word_t v1, input word_t v2, input logic p);
        wait_idle();
        drive_start(c, v1, v2, p);
    endtask

    task automatic run_and_check(input acc_t exp, input logic stray, input word_t stray_value);
        wait_idle();
        expected_sum = exp;
        arm          = 1'b1;
        drive_start(CMD_RUN, '0, '0, 1'b0);
        arm = 1'b0;
        if (stray) begin
            repeat (3) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            if (!busy) begin
                $display("stray start could not be placed inside a run at %0t ns", $time);
                tb_errors++;
            end
            drive_start(CMD_LD_X, stray_value, '0, 1'b0);   // Must be dropped
            drive_start(CMD_RUN, '0, '0, 1'b0);
        end
        wait_done();
        if (stray) begin
            repeat (QUIET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic end_test(input logic [127:0] name);
        test_name = name;
        test_end  = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        test_end = 1'b0;
    endtask

    task automatic report_bad_line(input logic [127:0] tok);
        $display("unreadable line in yzh_cases.txt starting with %0s", tok);
        tb_errors++;
    endtask

    task automatic process_line(input logic [8*128-1:0] text);
        logic [127:0] tok;
        logic [127:0] name;
        word_t        v1;
        word_t        v2;
        acc_t         exp;
        int           p;
        int           n;
        tok  = '0;
        name = '0;
        v1   = '0;
        v2   = '0;
        exp  = '0;
        p    = 0;
        n    = $sscanf(text, "%s", tok);
        if (n < 1 || tok == "#") begin
            // Blank or comment line
        end else if (tok == "LX" || tok == "LW") begin
            n = $sscanf(text, "%s %h %h %d", tok, v1, v2, p);
            if (n != 4) begin
                report_bad_line(tok);
            end else if (tok == "LX") begin
                send_cmd(CMD_LD_X, v1, v2, p[0]);
            end else begin
                send_cmd(CMD_LD_W, v1, v2, p[0]);
            end
        end else if (tok == "CX") begin
            send_cmd(CMD_CLR_X, '0, '0, 1'b0);
        end else if (tok == "CW") begin
            send_cmd(CMD_CLR_W, '0, '0, 1'b0);
        end else if (tok == "R") begin
            n = $sscanf(text, "%s %h", tok, exp);
            if (n != 2) report_bad_line(tok);
            else run_and_check(exp, 1'b0, '0);
        end else if (tok == "RB") begin
            n = $sscanf(text, "%s %h %h", tok, exp, v1);
            if (n != 3) report_bad_line(tok);
            else run_and_check(exp, 1'b1, v1);
        end else if (tok == "E") begin
            n = $sscanf(text, "%s %s", tok, name);
            end_test(name);
        end else begin
            report_bad_line(tok);
        end
    endtask

    task automatic run_cases();
        logic [8*128-1:0] line_buf;
        int               code;
        while (!$feof(fd)) begin
            line_buf = '0;
            code     = $fgets(line_buf, fd);
            if (code > 0) begin
                process_line(line_buf);
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        cmd          = CMD_NOP;
        start        = 1'b0;
        pair         = 1'b0;
        value1       = '0;
        value2       = '0;
        arm          = 1'b0;
        expected_sum = '0;
        test_end     = 1'b0;
        test_name    = '0;
        tb_errors    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        fd  = $fopen("yzh_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open yzh_cases.txt");
            $display("sim failed");
            $finish;
        end else begin
            run_cases();
            $fclose(fd);
            repeat (2) @(posedge clk);
            $display("summary: %0d tests, %0d failed, %0d runs checked, %0d errors",
                     tests, failed_tests, runs, errors + tb_errors);
            if (tests > 0 && failed_tests == 0 && errors == 0 && tb_errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

//--- yzh_top.sv
// Dot-product accelerator top
`timescale 1ns/1ps

module yzh_top
    import yzh_cmd_pkg::*;
    import yzh_data_pkg::*;
#(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  cmd_t  cmd_i,
    input  logic  start_i,
    input  logic  pair_i,
    input  word_t value1_i,
    input  word_t value2_i,
    output logic  busy_o,
    output logic  done_o,
    output acc_t  result_o
);

    logic  x_wr1_en;
    logic  x_wr2_en;
    logic  x_clr;
    logic  w_wr1_en;
    logic  w_wr2_en;
    logic  w_clr;
    logic  rd_rewind;
    logic  rd_en;
    logic  acc_clr;
    logic  acc_en;
    word_t x_data;
    word_t w_data;

    yzh_control #(
        .DEPTH(DEPTH)
    ) u_control (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cmd_i      (cmd_i),
        .start_i    (start_i),
        .pair_i     (pair_i),
        .x_wr1_en_o (x_wr1_en),
        .x_wr2_en_o (x_wr2_en),
        .x_clr_o    (x_clr),
        .w_wr1_en_o (w_wr1_en),
        .w_wr2_en_o (w_wr2_en),
        .w_clr_o    (w_clr),
        .rd_rewind_o(rd_rewind),
        .rd_en_o    (rd_en),
        .acc_clr_o  (acc_clr),
        .acc_en_o   (acc_en),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    yzh_operand_buffer #(
        .DEPTH(DEPTH),
        .WIDTH(WIDTH)
    ) u_x_buffer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .clr_i      (x_clr),
        .wr1_en_i   (x_wr1_en),
        .wr2_en_i   (x_wr2_en),
        .wr1_data_i (value1_i),
        .wr2_data_i (value2_i),
        .rd_rewind_i(rd_rewind),
        .rd_en_i    (rd_en),
        .rd_data_o  (x_data)
    );

    yzh_operand_buffer #(
        .DEPTH(DEPTH),
        .WIDTH(WIDTH)
    ) u_w_buffer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .clr_i      (w_clr),
        .wr1_en_i   (w_wr1_en),
        .wr2_en_i   (w_wr2_en),
        .wr1_data_i (value1_i),
        .wr2_data_i (value2_i),
        .rd_rewind_i(rd_rewind),
        .rd_en_i    (rd_en),
        .rd_data_o  (w_data)
    );

    yzh_mac u_mac (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .clr_i(acc_clr),
        .en_i (acc_en),
        .x_i  (x_data),
        .w_i  (w_data),
        .acc_o(result_o)
    );

endmodule
